// File: rv_decode_settings.svh
/*
 * RISC-V decode subsystem settings
 * FIFO depth and APB register offsets shared by the RTL and testbench
 */

`ifndef RV_DECODE_SETTINGS_SVH
`define RV_DECODE_SETTINGS_SVH

// Entries in both the instruction and the result FIFO
`define RVD_FIFO_DEPTH 4

// APB register map, byte offsets
// Write pushes one instruction word
`define RVD_ADDR_INSTR  4'h0
// Read pops one decoded record
`define RVD_ADDR_RESULT 4'h4
// Read only: result available, instr FIFO full, halted
`define RVD_ADDR_STATUS 4'h8
// Write bit0 to resume a halted decoder
`define RVD_ADDR_CTRL   4'hC

`endif

// File: rv_decode_pkg.sv
/*
 * RISC-V decode package
 * Opcode, format and ALU operation encodings plus the decoded record
 */

`default_nettype none

package rv_decode_pkg;

    // Plain data word and register index
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    // Major opcodes, instruction bits 6..2
    typedef enum logic [4:0] {
        OPCODE_LOAD     = 5'b00000,
        OPCODE_CUSTOM_0 = 5'b00010,
        OPCODE_MISC_MEM = 5'b00011,
        OPCODE_OP_IMM   = 5'b00100,
        OPCODE_AUIPC    = 5'b00101,
        OPCODE_STORE    = 5'b01000,
        OPCODE_AMO      = 5'b01011,
        OPCODE_OP       = 5'b01100,
        OPCODE_LUI      = 5'b01101,
        OPCODE_BRANCH   = 5'b11000,
        OPCODE_JALR     = 5'b11001,
        OPCODE_JAL      = 5'b11011,
        OPCODE_SYSTEM   = 5'b11100
    } opcode_e;

    typedef enum logic [2:0] {
        INSTR_FORMAT_R,
        INSTR_FORMAT_I,
        INSTR_FORMAT_S,
        INSTR_FORMAT_B,
        INSTR_FORMAT_U,
        INSTR_FORMAT_J,
        INSTR_FORMAT_OTHER
    } instr_format_e;

    // Low three bits are funct3, top bit is instruction bit 30
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SLL  = 4'b0001,
        ALU_SLT  = 4'b0010,
        ALU_SLTU = 4'b0011,
        ALU_XOR  = 4'b0100,
        ALU_SRL  = 4'b0101,
        ALU_OR   = 4'b0110,
        ALU_AND  = 4'b0111,
        ALU_SUB  = 4'b1000,
        ALU_SRA  = 4'b1101
    } aluop_e;

    // Decoded record, also the RESULT register layout
    typedef struct packed {
        logic [6:0]    zero;
        logic          halt;
        logic          rd_we;
        logic          illegal;
        aluop_e        alu_op;
        instr_format_e format;
        reg_idx_t      rs2;
        reg_idx_t      rs1;
        reg_idx_t      rd;
    } decoded_t;

endpackage : rv_decode_pkg

`default_nettype wire

// File: fifo_if.sv
/*
 * FIFO handshake interface
 * Push side and pop side of a buffer, payload type set per instance
 */

`timescale 1ns/10ps
`default_nettype none

interface fifo_if #(
    parameter type T = logic
) ();

    // Write side
    logic push;
    T     wdata;
    logic full;

    // Read side, rdata is the head entry while not empty
    logic pop;
    T     rdata;
    logic empty;

    modport writer (output push, output wdata, input full);

    modport reader (output pop, input rdata, input empty);

    modport fifo (
        input  push,
        input  wdata,
        output full,
        input  pop,
        output rdata,
        output empty
    );

endinterface : fifo_if

`default_nettype wire

// File: sync_fifo.sv
/*
 * Synchronous FIFO
 * Circular buffer with a type parameter so one block serves
 * both instruction words and decoded records
 */

`timescale 1ns/10ps
`default_nettype none

`include "rv_decode_settings.svh"

module sync_fifo #(
    parameter type T     = logic,
    parameter int  DEPTH = `RVD_FIFO_DEPTH
) (
    input logic  clk,
    input logic  rst_n,
    fifo_if.fifo q
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    T mem [DEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          push_ok;
    logic          pop_ok;

    // Pop needs data, push needs room or a pop freeing a slot
    assign pop_ok  = q.pop && !q.empty;
    assign push_ok = q.push && (!q.full || pop_ok);

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok) begin
                // Wrap by compare so DEPTH need not be a power of two
                if (wr_ptr == AW'(DEPTH - 1)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (pop_ok) begin
                if (rd_ptr == AW'(DEPTH - 1)) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
            // Count only moves when exactly one side is taken
            case ({push_ok, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage array
    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= q.wdata;
        end
    end

    // Head entry and flags
    assign q.rdata = mem[rd_ptr];
    assign q.empty = (count == '0);
    assign q.full  = (count == CW'(DEPTH));

endmodule : sync_fifo

`default_nettype wire

// File: apb_instr_port.sv
/*
 * APB register port of the decode subsystem
 * Pushes instruction words, pops decoded records, reports status
 * and issues the resume pulse to the decoder
 */

`timescale 1ns/10ps
`default_nettype none

`include "rv_decode_settings.svh"

module apb_instr_port
    import rv_decode_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,

    // APB slave side
    input  logic          psel,
    input  logic          penable,
    input  logic          pwrite,
    input  logic [3:0]    paddr,
    input  word_t         pwdata,
    output word_t         prdata,
    output logic          pready,
    output logic          pslverr,

    // Decoder control
    input  logic          halted,
    output logic          resume,

    // FIFO sides
    fifo_if.writer        instr_wr,
    fifo_if.reader        result_rd
);

    logic access;
    logic wr_access;
    logic rd_access;
    logic wr_instr;
    logic rd_result;
    logic wr_resume;

    // No wait states
    assign pready = 1'b1;

    // Access phase, transfer completes on this edge
    assign access    = psel && penable && pready;
    assign wr_access = access && pwrite;
    assign rd_access = access && !pwrite;

    // Register hits
    assign wr_instr  = wr_access && (paddr == `RVD_ADDR_INSTR);
    assign rd_result = rd_access && (paddr == `RVD_ADDR_RESULT);
    assign wr_resume = wr_access && (paddr == `RVD_ADDR_CTRL) && pwdata[0];

    // Push only with room, pop only with data
    assign instr_wr.push  = wr_instr && !instr_wr.full;
    assign instr_wr.wdata = pwdata;
    assign result_rd.pop  = rd_result && !result_rd.empty;

    // Overflowing write or underflowing read
    assign pslverr = (wr_instr && instr_wr.full) || (rd_result && result_rd.empty);

    // Read data mux
    always_comb begin
        prdata = '0;
        if (rd_access) begin
            case (paddr)
                `RVD_ADDR_RESULT: begin
                    if (!result_rd.empty) begin
                        prdata = word_t'(result_rd.rdata);
                    end
                end
                `RVD_ADDR_STATUS: begin
                    // bit0 result ready, bit1 instr FIFO full, bit2 halted
                    prdata = {29'd0, halted, instr_wr.full, !result_rd.empty};
                end
                default: prdata = '0;
            endcase
        end
    end

    // One cycle resume pulse
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            resume <= 1'b0;
        end else begin
            resume <= wr_resume;
        end
    end

endmodule : apb_instr_port

`default_nettype wire

// File: instr_decoder.sv
/*
 * RISC-V instruction decoder
 * INIT/RUN/HALT state machine pops instruction words, decodes them
 * into one registered stage and drains records into the result FIFO
 */

`timescale 1ns/10ps
`default_nettype none

module instr_decoder
    import rv_decode_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   resume,
    output logic   halted,
    fifo_if.reader instr_rd,
    fifo_if.writer result_wr
);

    typedef enum logic [1:0] {
        INIT,
        RUN,
        HALT
    } state_e;

    state_e   state_ff;
    state_e   next_state;

    word_t    instr;
    opcode_e  opcode;
    logic     unsupported_opcode;
    decoded_t dec;

    // Output stage
    decoded_t out_rec;
    logic     out_valid;
    logic     out_push;
    logic     stage_free;
    logic     take;

    assign instr  = instr_rd.rdata;
    assign opcode = opcode_e'(instr[6:2]);

    // Stage drains whenever result FIFO has room
    assign out_push   = out_valid && !result_wr.full;
    assign stage_free = !out_valid || out_push;
    assign take       = (state_ff == RUN) && !instr_rd.empty && stage_free;

    assign instr_rd.pop    = take;
    assign result_wr.push  = out_push;
    assign result_wr.wdata = out_rec;
    assign halted          = (state_ff == HALT);

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            state_ff <= INIT;
        end else begin
            state_ff <= next_state;
        end
    end

    always_comb begin
        next_state = state_ff;
        unique case (state_ff)
            INIT: next_state = RUN;
            RUN: begin
                // CUSTOM-0 stops further pops once taken
                if (take && dec.halt) begin
                    next_state = HALT;
                end
            end
            HALT: begin
                if (resume) begin
                    next_state = RUN;
                end
            end
            default: next_state = HALT;   // Unknown state, park
        endcase
    end

    // Supported opcode list
    always_comb begin
        unique case (opcode)
            OPCODE_LOAD, OPCODE_CUSTOM_0, OPCODE_MISC_MEM, OPCODE_OP_IMM,
            OPCODE_AUIPC, OPCODE_STORE, OPCODE_AMO, OPCODE_OP, OPCODE_LUI,
            OPCODE_BRANCH, OPCODE_JALR, OPCODE_JAL, OPCODE_SYSTEM: begin
                unsupported_opcode = 1'b0;
            end
            default: unsupported_opcode = 1'b1;
        endcase
    end

    // Combinational decode of the head word
    always_comb begin
        dec         = '0;
        dec.rd      = instr[11:7];
        dec.rs1     = instr[19:15];
        dec.rs2     = instr[24:20];
        dec.illegal = unsupported_opcode || (instr[1:0] != 2'b11)
                      || (instr == 32'h0) || (instr == 32'hFFFF_FFFF);
        dec.halt    = (opcode == OPCODE_CUSTOM_0);

        unique case (opcode)
            OPCODE_OP, OPCODE_AMO:                                    dec.format = INSTR_FORMAT_R;
            OPCODE_LOAD, OPCODE_MISC_MEM, OPCODE_OP_IMM, OPCODE_JALR: dec.format = INSTR_FORMAT_I;
            OPCODE_STORE:                                             dec.format = INSTR_FORMAT_S;
            OPCODE_BRANCH:                                            dec.format = INSTR_FORMAT_B;
            OPCODE_LUI, OPCODE_AUIPC:                                 dec.format = INSTR_FORMAT_U;
            OPCODE_JAL:                                               dec.format = INSTR_FORMAT_J;
            default:                                                  dec.format = INSTR_FORMAT_OTHER;
        endcase

        // funct3 in low bits, bit 30 selects SUB/SRA variants
        unique case (opcode)
            OPCODE_OP:     dec.alu_op = aluop_e'({instr[30], instr[14:12]});
            OPCODE_OP_IMM: begin
                if (instr[14:12] == 3'd5) begin
                    dec.alu_op = aluop_e'({instr[30], instr[14:12]});
                end else begin
                    dec.alu_op = aluop_e'({1'b0, instr[14:12]});
                end
            end
            default:       dec.alu_op = ALU_ADD;
        endcase

        // Fences write nothing
        dec.rd_we = !dec.illegal && (opcode != OPCODE_MISC_MEM)
                    && (dec.format inside {INSTR_FORMAT_R, INSTR_FORMAT_I,
                                           INSTR_FORMAT_U, INSTR_FORMAT_J});
    end

    // Stage valid flag
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (take) begin
            out_valid <= 1'b1;
        end else if (out_push) begin
            out_valid <= 1'b0;
        end
    end

    // Stage payload, held under back-pressure
    always_ff @(posedge clk) begin
        if (take) begin
            out_rec <= dec;
        end
    end

endmodule : instr_decoder

`default_nettype wire

// File: rv_decode_top.sv
/*
 * RISC-V decode subsystem top
 * APB port feeding an instruction FIFO, the decoder and a result FIFO
 */

`timescale 1ns/10ps
`default_nettype none

module rv_decode_top
    import rv_decode_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    // APB slave
    input  logic       psel,
    input  logic       penable,
    input  logic       pwrite,
    input  logic [3:0] paddr,
    input  word_t      pwdata,
    output word_t      prdata,
    output logic       pready,
    output logic       pslverr
);

    logic halted;
    logic resume;

    // Instruction words toward the decoder, records back to the host
    fifo_if #(.T(word_t))    instr_q ();
    fifo_if #(.T(decoded_t)) result_q ();

    apb_instr_port u_apb (
        .clk       (clk),
        .rst_n     (rst_n),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .halted    (halted),
        .resume    (resume),
        .instr_wr  (instr_q.writer),
        .result_rd (result_q.reader)
    );

    sync_fifo #(.T(word_t)) u_instr_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .q     (instr_q.fifo)
    );

    instr_decoder u_decoder (
        .clk       (clk),
        .rst_n     (rst_n),
        .resume    (resume),
        .halted    (halted),
        .instr_rd  (instr_q.reader),
        .result_wr (result_q.writer)
    );

    sync_fifo #(.T(decoded_t)) u_result_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .q     (result_q.fifo)
    );

endmodule : rv_decode_top

`default_nettype wire

// File: rv_decode_props.sv
/*
 * Protocol and FIFO checks for the decode subsystem
 * Bound into the top level, watches the APB port, both FIFOs and halt
 */

`timescale 1ns/10ps
`default_nettype none

module rv_decode_props (
    input logic clk,
    input logic rst_n,
    input logic pready,
    input logic halted,
    input logic instr_push,
    input logic instr_full,
    input logic instr_pop,
    input logic instr_empty,
    input logic result_push,
    input logic result_full,
    input logic result_pop,
    input logic result_empty
);

    // Zero wait state slave
    pready_high: assert property (@(posedge clk) disable iff (!rst_n) pready)
        else $error("pready dropped low");

    // Writers and readers respect the FIFO flags
    instr_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        !(instr_push && instr_full))
        else $error("instr_q pushed while full");
    instr_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        !(instr_pop && instr_empty))
        else $error("instr_q popped while empty");
    result_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        !(result_push && result_full))
        else $error("result_q pushed while full");
    result_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        !(result_pop && result_empty))
        else $error("result_q popped while empty");

    // INIT then RUN, never straight into HALT
    halted_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> !halted ##1 !halted)
        else $error("halted rose right after reset");

    // A halted decoder takes nothing
    no_pop_while_halted: assert property (@(posedge clk) disable iff (!rst_n)
        !(instr_pop && halted))
        else $error("instr_q popped while halted");

endmodule : rv_decode_props

bind rv_decode_top rv_decode_props u_props (
    .clk          (clk),
    .rst_n        (rst_n),
    .pready       (pready),
    .halted       (halted),
    .instr_push   (instr_q.push),
    .instr_full   (instr_q.full),
    .instr_pop    (instr_q.pop),
    .instr_empty  (instr_q.empty),
    .result_push  (result_q.push),
    .result_full  (result_q.full),
    .result_pop   (result_q.pop),
    .result_empty (result_q.empty)
);

`default_nettype wire

// File: tb_rv_decode.sv
/*
 * Testbench for the RISC-V decode subsystem
 * Drives APB transfers, decodes a reference copy of every word and
 * compares each RESULT read against it
 */

`timescale 1ns/10ps
`default_nettype none

`include "rv_decode_settings.svh"

module tb_rv_decode
    import rv_decode_pkg::*;
();

    logic        clk;
    logic        rst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    word_t       pwdata;
    word_t       prdata;
    logic        pready;
    logic        pslverr;

    // Expected records in write order
    decoded_t    exp_q[$];
    // Words of the next write-all then read-all batch
    word_t       batch[$];
    logic [31:0] lfsr;

    rv_decode_top dut0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Watchdog for the whole run
    initial begin
        #1_000_000;
        $display("Simulation did not finish within its time limit");
        stop_failed();
    end

    task automatic stop_failed();
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input word_t got, input word_t exp);
        assert (got == exp) else begin
            $display("Error: %s got %h expected %h", name, got, exp);
            stop_failed();
        end
    endtask

    // Galois LFSR with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end else begin
            return s >> 1;
        end
    endfunction

    // One LFSR step per bit taken
    function automatic word_t rand_bits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // R-type field layout that the other formats share bit for bit
    function automatic word_t encode(input logic [6:0] f7, input reg_idx_t rs2,
                                     input reg_idx_t rs1, input logic [2:0] f3,
                                     input reg_idx_t rd, input logic [4:0] op);
        return {f7, rs2, rs1, f3, rd, op, 2'b11};
    endfunction

    // Expected decode built from the field and legality rules
    function automatic decoded_t ref_decode(input word_t w);
        decoded_t   d;
        logic [4:0] op;
        logic       known;
        logic       writes;
        op     = w[6:2];
        d      = '0;
        writes = 1'b0;
        d.rd   = w[11:7];
        d.rs1  = w[19:15];
        d.rs2  = w[24:20];
        known  = op inside {OPCODE_LOAD, OPCODE_CUSTOM_0, OPCODE_MISC_MEM, OPCODE_OP_IMM,
                            OPCODE_AUIPC, OPCODE_STORE, OPCODE_AMO, OPCODE_OP, OPCODE_LUI,
                            OPCODE_BRANCH, OPCODE_JALR, OPCODE_JAL, OPCODE_SYSTEM};
        d.illegal = !known || (w[1:0] != 2'b11) || (w == 32'h0) || (&w);
        d.halt    = (op == OPCODE_CUSTOM_0);
        d.format  = INSTR_FORMAT_OTHER;
        if (op == OPCODE_OP || op == OPCODE_AMO) begin
            d.format = INSTR_FORMAT_R;
            writes   = 1'b1;
        end else if (op inside {OPCODE_LOAD, OPCODE_MISC_MEM, OPCODE_OP_IMM, OPCODE_JALR}) begin
            d.format = INSTR_FORMAT_I;
            writes   = 1'b1;
        end else if (op == OPCODE_STORE) begin
            d.format = INSTR_FORMAT_S;
        end else if (op == OPCODE_BRANCH) begin
            d.format = INSTR_FORMAT_B;
        end else if (op == OPCODE_LUI || op == OPCODE_AUIPC) begin
            d.format = INSTR_FORMAT_U;
            writes   = 1'b1;
        end else if (op == OPCODE_JAL) begin
            d.format = INSTR_FORMAT_J;
            writes   = 1'b1;
        end
        // Bit 30 only matters for OP and for shifts right of OP_IMM
        if (op == OPCODE_OP || (op == OPCODE_OP_IMM && w[14:12] == 3'd5)) begin
            d.alu_op = aluop_e'({w[30], w[14:12]});
        end else if (op == OPCODE_OP_IMM) begin
            d.alu_op = aluop_e'({1'b0, w[14:12]});
        end
        d.rd_we = writes && !d.illegal && (op != OPCODE_MISC_MEM);
        return d;
    endfunction

    // Setup on one falling edge and access on the next, then idle after the completing edge
    task automatic apb_xfer(input logic wr, input logic [3:0] addr, input word_t wdata,
                            output word_t rdata, output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        // Outputs settle well before the completing rising edge
        #1;
        rdata = prdata;
        err   = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic write_instr(input word_t w, input logic exp_err);
        word_t rd;
        logic  err;
        apb_xfer(1'b1, `RVD_ADDR_INSTR, w, rd, err);
        check_value("pslverr", word_t'(err), word_t'(exp_err));
        if (!err) begin
            exp_q.push_back(ref_decode(w));
        end
    endtask

    task automatic check_status(input word_t exp);
        word_t rd;
        logic  err;
        apb_xfer(1'b0, `RVD_ADDR_STATUS, '0, rd, err);
        check_value("STATUS", rd, exp);
    endtask

    task automatic wait_result();
        word_t st;
        logic  err;
        int    tries;
        st    = '0;
        tries = 0;
        while (!st[0]) begin
            if (tries == 40) begin
                $display("Timed out waiting for STATUS to show a result");
                stop_failed();
            end else begin
                apb_xfer(1'b0, `RVD_ADDR_STATUS, '0, st, err);
                tries++;
            end
        end
    endtask

    task automatic pop_check(output logic halt_seen);
        word_t    got;
        logic     err;
        decoded_t exp;
        decoded_t rec;
        halt_seen = 1'b0;
        wait_result();
        apb_xfer(1'b0, `RVD_ADDR_RESULT, '0, got, err);
        if (exp_q.size() == 0) begin
            $display("A result came back with no instruction outstanding");
            stop_failed();
        end else begin
            exp = exp_q.pop_front();
            check_value("pslverr", word_t'(err), 32'h0);
            check_value("RESULT", got, word_t'(exp));
            // Halt flag as the DUT reported it
            rec       = decoded_t'(got);
            halt_seen = rec.halt;
        end
    endtask

    task automatic run_batch();
        logic halt_seen;
        foreach (batch[i]) begin
            write_instr(batch[i], 1'b0);
        end
        foreach (batch[i]) begin
            pop_check(halt_seen);
        end
        batch.delete();
    endtask

    initial begin
        word_t rd;
        logic  err;
        logic  halt_seen;
        word_t w;
        rst_n   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        lfsr    = 32'h2069;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Idle status and a RESULT read with nothing decoded
        check_status(32'h0);
        apb_xfer(1'b0, `RVD_ADDR_RESULT, '0, rd, err);
        check_value("pslverr", word_t'(err), 32'h1);
        check_value("prdata", rd, 32'h0);

        // Legal words of every format
        batch.push_back(encode(7'h00, 5'd2, 5'd1, 3'd0, 5'd3, OPCODE_OP));
        batch.push_back(encode(7'h20, 5'd7, 5'd6, 3'd5, 5'd5, OPCODE_OP));
        batch.push_back(encode(7'h20, 5'd31, 5'd9, 3'd5, 5'd8, OPCODE_OP_IMM));
        batch.push_back(encode(7'h20, 5'd4, 5'd10, 3'd0, 5'd11, OPCODE_OP_IMM));
        batch.push_back(encode(7'h01, 5'd12, 5'd13, 3'd2, 5'd14, OPCODE_LOAD));
        batch.push_back(encode(7'h05, 5'd15, 5'd16, 3'd2, 5'd17, OPCODE_STORE));
        run_batch();
        batch.push_back(encode(7'h3f, 5'd18, 5'd19, 3'd1, 5'd20, OPCODE_BRANCH));
        batch.push_back(encode(7'h55, 5'd21, 5'd22, 3'd7, 5'd23, OPCODE_LUI));
        batch.push_back(encode(7'h2a, 5'd24, 5'd25, 3'd6, 5'd26, OPCODE_AUIPC));
        batch.push_back(encode(7'h7f, 5'd27, 5'd28, 3'd3, 5'd29, OPCODE_JAL));
        batch.push_back(encode(7'h00, 5'd30, 5'd31, 3'd0, 5'd1, OPCODE_JALR));
        batch.push_back(encode(7'h00, 5'd0, 5'd0, 3'd0, 5'd0, OPCODE_MISC_MEM));
        batch.push_back(encode(7'h08, 5'd3, 5'd4, 3'd2, 5'd5, OPCODE_AMO));
        batch.push_back(encode(7'h00, 5'd0, 5'd0, 3'd1, 5'd6, OPCODE_SYSTEM));
        run_batch();

        // Illegal words
        w = encode(7'h00, 5'd2, 5'd1, 3'd0, 5'd3, OPCODE_OP);
        batch.push_back(32'h0);
        batch.push_back(32'hFFFF_FFFF);
        batch.push_back({w[31:2], 2'b01});
        batch.push_back(encode(7'h00, 5'd1, 5'd2, 3'd0, 5'd3, 5'b00001));
        batch.push_back(encode(7'h11, 5'd4, 5'd5, 3'd4, 5'd6, 5'b10110));
        run_batch();

        // CUSTOM_0 halts the decoder so the fifth write overflows the stalled instr_q
        write_instr(encode(7'h00, 5'd1, 5'd2, 3'd0, 5'd4, OPCODE_CUSTOM_0), 1'b0);
        pop_check(halt_seen);
        check_value("halt", word_t'(halt_seen), 32'h1);
        check_status(32'h4);
        for (int i = 0; i < 5; i++) begin
            write_instr(encode(7'h20, 5'(i), 5'(i + 1), 3'(i), 5'(i + 2), OPCODE_OP_IMM),
                        (i == 4));
        end
        repeat (4) check_status(32'h6);
        apb_xfer(1'b1, `RVD_ADDR_CTRL, 32'h1, rd, err);
        repeat (4) pop_check(halt_seen);
        check_status(32'h0);

        // Eight writes before any read let result_q fill and back-pressure the decoder
        for (int i = 0; i < 8; i++) begin
            batch.push_back(encode({1'b0, i[0], 5'd0}, 5'(i), 5'(i + 8), 3'(i),
                                   5'(i + 16), OPCODE_OP));
        end
        run_batch();

        // Random words with low bits forced to 11 on a coin flip
        for (int n = 0; n < 40; n++) begin
            w = rand_bits(32);
            if (rand_bits(1) != 32'h0) begin
                w[1:0] = 2'b11;
            end
            write_instr(w, 1'b0);
            pop_check(halt_seen);
            if (halt_seen) begin
                apb_xfer(1'b1, `RVD_ADDR_CTRL, 32'h1, rd, err);
            end
        end
        check_status(32'h0);

        $display("Everything OK");
        $finish;
    end

endmodule : tb_rv_decode

`default_nettype wire

// File: build.f
+incdir+.
rv_decode_pkg.sv
fifo_if.sv
sync_fifo.sv
apb_instr_port.sv
instr_decoder.sv
rv_decode_top.sv
rv_decode_props.sv
tb_rv_decode.sv

// File: run.sh
#!/bin/sh
# Compile the decode testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_rv_decode -f build.f -o tb_rv_decode
./obj_dir/tb_rv_decode
